// File: flist.f
hdl/rcc_sync_pkg.sv
hdl/rcc_bit_sync.sv
hdl/rcc_reset_sync.sv
hdl/rcc_signal_rst_sync.sv
hdl/rcc_rdy_flags.sv
hdl/rcc_int_regs.sv
hdl/rcc_top.sv
tb/tb_rcc_top.sv

// File: Makefile
TOP := tb_rcc_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb/tb_rcc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rcc_top;

  import rcc_sync_pkg::*;

  // The expected line column is {irq, nmi, hse_css_rst_n}.
  typedef struct {
    string     name;
    osc_vec_t  osc;
    css_vec_t  css;
    logic      wr;
    rcc_addr_t waddr;
    rcc_word_t wdata;
    rcc_addr_t raddr;
    rcc_word_t exp_rdata;
    logic [2:0] exp_lines;
  } row_t;

  localparam int RAND_ROWS = 8;

  logic      rcc_hclk = 1'b0;
  logic      rst_n;
  osc_vec_t  osc_rdy;
  css_vec_t  css_fail;
  logic      wr_en;
  rcc_addr_t addr;
  rcc_word_t wdata;
  rcc_word_t rdata;
  logic      irq;
  logic      nmi;
  logic      sys_rst_sync_n;
  logic      hse_css_rst_n;

  row_t rows[$];
  int   check_count = 0;
  int   err_count = 0;
  int   cycle_cnt = 0;
  int   timeout_limit = 1000;

  rcc_top dut (
    .rcc_hclk      (rcc_hclk),
    .rst_n         (rst_n),
    .osc_rdy       (osc_rdy),
    .css_fail      (css_fail),
    .wr_en         (wr_en),
    .addr          (addr),
    .wdata         (wdata),
    .rdata         (rdata),
    .irq           (irq),
    .nmi           (nmi),
    .sys_rst_sync_n(sys_rst_sync_n),
    .hse_css_rst_n (hse_css_rst_n)
  );

  always #2 rcc_hclk = ~rcc_hclk;

  always @(posedge rcc_hclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles.", timeout_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_vec(input string name, input osc_vec_t exp, input osc_vec_t act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input rcc_word_t exp, input rcc_word_t act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("Error: %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic add_row(input string name, input osc_vec_t osc, input css_vec_t css,
                         input logic wr, input rcc_addr_t waddr, input rcc_word_t wdat,
                         input rcc_addr_t raddr, input rcc_word_t exp_rdata,
                         input logic [2:0] exp_lines);
    row_t r;
    r = '{name, osc, css, wr, waddr, wdat, raddr, exp_rdata, exp_lines};
    rows.push_back(r);
  endtask

  task automatic build_table();
    logic [31:0] state;
    osc_vec_t    prev;
    osc_vec_t    acc;
    state = 32'd16;
    prev  = '0;
    acc   = '0;
    // name, osc_rdy, css_fail, wr_en, write addr, wdata, read addr, rdata, lines
    add_row("rst_ier", 9'h000, 2'b00, 1'b0, ADDR_IER, 16'h0000, ADDR_IER, 16'h0000, 3'b001);
    add_row("rst_ifr", 9'h000, 2'b00, 1'b0, ADDR_IER, 16'h0000, ADDR_IFR, 16'h0000, 3'b001);
    add_row("rdy_rise", 9'h00B, 2'b00, 1'b0, ADDR_IER, 16'h0000, ADDR_RDY, 16'h000B, 3'b001);
    add_row("ifr_rise", 9'h00B, 2'b00, 1'b0, ADDR_IER, 16'h0000, ADDR_IFR, 16'h000B, 3'b001);
    add_row("rdy_fall", 9'h003, 2'b00, 1'b0, ADDR_IER, 16'h0000, ADDR_IFR, 16'h000B, 3'b001);
    add_row("pll3_rise", 9'h103, 2'b00, 1'b0, ADDR_IER, 16'h0000, ADDR_IFR, 16'h010B, 3'b001);
    add_row("ier_all", 9'h103, 2'b00, 1'b1, ADDR_IER, 16'hFFFF, ADDR_IER, 16'h07FF, 3'b101);
    add_row("ier_hsi48", 9'h103, 2'b00, 1'b1, ADDR_IER, 16'h0004, ADDR_IER, 16'h0004, 3'b001);
    add_row("ier_hse", 9'h103, 2'b00, 1'b1, ADDR_IER, 16'h0008, ADDR_IER, 16'h0008, 3'b101);
    add_row("icr_hse", 9'h103, 2'b00, 1'b1, ADDR_ICR, 16'h0008, ADDR_IFR, 16'h0103, 3'b001);
    add_row("icr_read", 9'h103, 2'b00, 1'b0, ADDR_IER, 16'h0000, ADDR_ICR, 16'h0000, 3'b001);
    add_row("hse_again", 9'h10B, 2'b00, 1'b0, ADDR_IER, 16'h0000, ADDR_IFR, 16'h010B, 3'b101);
    add_row("icr_osc", 9'h10B, 2'b00, 1'b1, ADDR_ICR, 16'h01FF, ADDR_IFR, 16'h0000, 3'b001);
    // Clock security monitors. IER holds only bit 3 here.
    add_row("lse_masked", 9'h10B, 2'b01, 1'b0, ADDR_IER, 16'h0000, ADDR_IFR, 16'h0200, 3'b001);
    add_row("lse_enable", 9'h10B, 2'b01, 1'b1, ADDR_IER, 16'h0200, ADDR_IFR, 16'h0200, 3'b101);
    add_row("hse_fail", 9'h10B, 2'b11, 1'b0, ADDR_IER, 16'h0000, ADDR_IFR, 16'h0600, 3'b110);
    add_row("hse_fail_end", 9'h10B, 2'b01, 1'b0, ADDR_IER, 16'h0000, ADDR_IFR, 16'h0600, 3'b111);
    add_row("icr_lse", 9'h10B, 2'b00, 1'b1, ADDR_ICR, 16'h0200, ADDR_IFR, 16'h0400, 3'b011);
    add_row("icr_hse_css", 9'h10B, 2'b00, 1'b1, ADDR_ICR, 16'h0400, ADDR_IFR, 16'h0000, 3'b001);
    add_row("rand_setup", 9'h000, 2'b00, 1'b1, ADDR_IER, 16'h01FF, ADDR_IER, 16'h01FF, 3'b001);
    // Flags start empty and every ready source is enabled.
    for (int n = 0; n < RAND_ROWS; n++) begin
      state = lcg_next(state);
      acc   = acc | (state[24:16] & ~prev);
      prev  = state[24:16];
      add_row($sformatf("rand_%0d", n), state[24:16], 2'b00, 1'b0, ADDR_IER, 16'h0000,
              ADDR_IFR, {7'b0, acc}, {|acc, 1'b0, 1'b1});
    end
  endtask

  task automatic run_row(input row_t r);
    @(negedge rcc_hclk);
    osc_rdy  = r.osc;
    css_fail = r.css;
    wr_en    = r.wr;
    addr     = r.waddr;
    wdata    = r.wdata;
    #1;
    // The HSE reset asserts without waiting for a clock edge.
    if (r.css[CSS_HSE_IDX]) begin
      check_bit({r.name, "_hse_rst_now"}, 1'b0, hse_css_rst_n);
    end
    @(negedge rcc_hclk);
    wr_en = 1'b0;
    addr  = r.raddr;
    wdata = '0;
    repeat (5) @(negedge rcc_hclk);
    check_word(r.name, r.exp_rdata, rdata);
    check_bit({r.name, "_irq"}, r.exp_lines[2], irq);
    check_bit({r.name, "_nmi"}, r.exp_lines[1], nmi);
    check_bit({r.name, "_hse_rst"}, r.exp_lines[0], hse_css_rst_n);
    addr = ADDR_RDY;
    #1;
    check_vec({r.name, "_rdy"}, r.osc, rdata[OSC_NUM-1:0]);
  endtask

  initial begin
    rst_n    = 1'b0;
    osc_rdy  = '0;
    css_fail = '0;
    wr_en    = 1'b0;
    addr     = ADDR_RDY;
    wdata    = '0;
    build_table();
    timeout_limit = rows.size() * 10 + 40;
    repeat (16) @(posedge rcc_hclk);
    @(negedge rcc_hclk);
    check_bit("sys_rst_held", 1'b0, sys_rst_sync_n);
    check_bit("hse_rst_held", 1'b0, hse_css_rst_n);
    rst_n = 1'b1;
    // Release needs two edges.
    @(posedge rcc_hclk);
    #1;
    check_bit("sys_rst_edge1", 1'b0, sys_rst_sync_n);
    @(posedge rcc_hclk);
    #1;
    check_bit("sys_rst_edge2", 1'b1, sys_rst_sync_n);
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    $display("Checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/rcc_top.sv
`timescale 1ns/1ps
`default_nettype none

module rcc_top (
  input  logic                    rcc_hclk,
  input  logic                    rst_n,
  input  rcc_sync_pkg::osc_vec_t  osc_rdy,
  input  rcc_sync_pkg::css_vec_t  css_fail,
  input  logic                    wr_en,
  input  rcc_sync_pkg::rcc_addr_t addr,
  input  rcc_sync_pkg::rcc_word_t wdata,
  output rcc_sync_pkg::rcc_word_t rdata,
  output logic                    irq,
  output logic                    nmi,
  output logic                    sys_rst_sync_n,
  output logic                    hse_css_rst_n
);

  import rcc_sync_pkg::*;

  osc_vec_t  rdy_sync;
  css_vec_t  css_sync;
  rcc_word_t clr_mask;
  rcc_word_t flags;

  rcc_signal_rst_sync u_signal_rst_sync (
    .rcc_hclk      (rcc_hclk),
    .rst_n         (rst_n),
    .osc_rdy       (osc_rdy),
    .css_fail      (css_fail),
    .rdy_sync      (rdy_sync),
    .css_sync      (css_sync),
    .sys_rst_sync_n(sys_rst_sync_n),
    .hse_css_rst_n (hse_css_rst_n)
  );

  rcc_rdy_flags u_rdy_flags (
    .rcc_hclk(rcc_hclk),
    .rst_n   (rst_n),
    .rdy_sync(rdy_sync),
    .css_sync(css_sync),
    .clr_mask(clr_mask),
    .flags   (flags)
  );

  rcc_int_regs u_int_regs (
    .rcc_hclk(rcc_hclk),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .addr    (addr),
    .wdata   (wdata),
    .rdy_sync(rdy_sync),
    .flags   (flags),
    .rdata   (rdata),
    .clr_mask(clr_mask),
    .irq     (irq),
    .nmi     (nmi)
  );

endmodule

`default_nettype wire

// File: hdl/rcc_int_regs.sv
`timescale 1ns/1ps
`default_nettype none

module rcc_int_regs (
  input  logic                    rcc_hclk,
  input  logic                    rst_n,
  input  logic                    wr_en,
  input  rcc_sync_pkg::rcc_addr_t addr,
  input  rcc_sync_pkg::rcc_word_t wdata,
  input  rcc_sync_pkg::osc_vec_t  rdy_sync,
  input  rcc_sync_pkg::rcc_word_t flags,
  output rcc_sync_pkg::rcc_word_t rdata,
  output rcc_sync_pkg::rcc_word_t clr_mask,
  output logic                    irq,
  output logic                    nmi
);

  import rcc_sync_pkg::*;

  rcc_word_t ier_q;
  logic      wr_ier;
  logic      wr_icr;

  assign wr_ier = wr_en && (addr == ADDR_IER);
  assign wr_icr = wr_en && (addr == ADDR_ICR);

  always_ff @(posedge rcc_hclk or negedge rst_n) begin
    if (!rst_n) begin
      ier_q <= '0;
    end else if (wr_ier) begin
      ier_q <= wdata & FIELD_MASK;
    end
  end

  // The clear acts on the write edge itself.
  assign clr_mask = wr_icr ? wdata : '0;

  always_comb begin
    rdata = '0;
    case (addr)
      ADDR_RDY: rdata[OSC_FIELD_LSB +: OSC_NUM] = rdy_sync;
      ADDR_IER: rdata = ier_q;
      ADDR_IFR: rdata = flags;
      default:  rdata = '0;
    endcase
  end

  // Ready sources and the LSE monitor share the maskable line.
  assign irq = |(flags[CSS_LSE_BIT:OSC_FIELD_LSB] & ier_q[CSS_LSE_BIT:OSC_FIELD_LSB]);

  // An HSE failure cannot be masked
  assign nmi = flags[CSS_HSE_BIT];

endmodule

`default_nettype wire

// File: hdl/rcc_rdy_flags.sv
`timescale 1ns/1ps
`default_nettype none

module rcc_rdy_flags (
  input  logic                    rcc_hclk,
  input  logic                    rst_n,
  input  rcc_sync_pkg::osc_vec_t  rdy_sync,
  input  rcc_sync_pkg::css_vec_t  css_sync,
  input  rcc_sync_pkg::rcc_word_t clr_mask,
  output rcc_sync_pkg::rcc_word_t flags
);

  import rcc_sync_pkg::*;

  osc_vec_t  rdy_prev_q;
  css_vec_t  css_prev_q;
  rcc_word_t set_vec;
  rcc_word_t flags_q;

  always_ff @(posedge rcc_hclk or negedge rst_n) begin
    if (!rst_n) begin
      rdy_prev_q <= '0;
      css_prev_q <= '0;
    end else begin
      rdy_prev_q <= rdy_sync;
      css_prev_q <= css_sync;
    end
  end

  // Rising edges only, placed at the register field positions.
  always_comb begin
    set_vec = '0;
    set_vec[OSC_FIELD_LSB +: OSC_NUM] = rdy_sync & ~rdy_prev_q;
    set_vec[CSS_LSE_BIT] = css_sync[CSS_LSE_IDX] & ~css_prev_q[CSS_LSE_IDX];
    set_vec[CSS_HSE_BIT] = css_sync[CSS_HSE_IDX] & ~css_prev_q[CSS_HSE_IDX];
  end

  // A new event in the same cycle outranks the clear.
  always_ff @(posedge rcc_hclk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
    end else begin
      flags_q <= (flags_q & ~clr_mask) | set_vec;
    end
  end

  assign flags = flags_q;

endmodule

`default_nettype wire

// File: hdl/rcc_signal_rst_sync.sv
`timescale 1ns/1ps
`default_nettype none

module rcc_signal_rst_sync (
  input  logic                   rcc_hclk,
  input  logic                   rst_n,
  input  rcc_sync_pkg::osc_vec_t osc_rdy,
  input  rcc_sync_pkg::css_vec_t css_fail,
  output rcc_sync_pkg::osc_vec_t rdy_sync,
  output rcc_sync_pkg::css_vec_t css_sync,
  output logic                   sys_rst_sync_n,
  output logic                   hse_css_rst_n
);

  import rcc_sync_pkg::*;

  logic hse_css_src_n;

  // An HSE security failure resets the logic behind it.
  // The system reset does too.
  assign hse_css_src_n = rst_n & ~css_fail[CSS_HSE_IDX];

  rcc_bit_sync #(
    .data_t   (osc_vec_t),
    .STAGE_NUM(SYNC_STAGES)
  ) u_rdy_sync (
    .rcc_hclk(rcc_hclk),
    .rst_n   (rst_n),
    .src     (osc_rdy),
    .dst     (rdy_sync)
  );

  rcc_bit_sync #(
    .data_t   (css_vec_t),
    .STAGE_NUM(SYNC_STAGES)
  ) u_css_sync (
    .rcc_hclk(rcc_hclk),
    .rst_n   (rst_n),
    .src     (css_fail),
    .dst     (css_sync)
  );

  rcc_reset_sync #(
    .STAGE_NUM(SYNC_STAGES)
  ) u_sys_rst_sync (
    .rcc_hclk (rcc_hclk),
    .src_rst_n(rst_n),
    .gen_rst_n(sys_rst_sync_n)
  );

  rcc_reset_sync #(
    .STAGE_NUM(SYNC_STAGES)
  ) u_hse_css_rst_sync (
    .rcc_hclk (rcc_hclk),
    .src_rst_n(hse_css_src_n),
    .gen_rst_n(hse_css_rst_n)
  );

endmodule

`default_nettype wire

// File: hdl/rcc_reset_sync.sv
`timescale 1ns/1ps
`default_nettype none

// The source reset clears the chain at once.
// Ones then shift in, so release takes STAGE_NUM edges.
// STAGE_NUM must be at least 2.
module rcc_reset_sync #(
  parameter int unsigned STAGE_NUM = 2
) (
  input  logic rcc_hclk,
  input  logic src_rst_n,
  output logic gen_rst_n
);

  logic [STAGE_NUM-1:0] rst_shift_q;

  always_ff @(posedge rcc_hclk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      rst_shift_q <= '0;
    end else begin
      rst_shift_q <= {rst_shift_q[STAGE_NUM-2:0], 1'b1};
    end
  end

  assign gen_rst_n = rst_shift_q[STAGE_NUM-1];

endmodule

`default_nettype wire

// File: hdl/rcc_bit_sync.sv
`timescale 1ns/1ps
`default_nettype none

// Only for quasi-static levels; a multi-bit payload is not guaranteed coherent.
module rcc_bit_sync #(
  parameter type         data_t    = logic,
  parameter int unsigned STAGE_NUM = 2
) (
  input  logic  rcc_hclk,
  input  logic  rst_n,
  input  data_t src,
  output data_t dst
);

  data_t stage_q [STAGE_NUM];

  always_ff @(posedge rcc_hclk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < STAGE_NUM; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= src;
      for (int i = 1; i < STAGE_NUM; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign dst = stage_q[STAGE_NUM-1];

endmodule

`default_nettype wire

// File: hdl/rcc_sync_pkg.sv
`default_nettype none

package rcc_sync_pkg;

  // Ready sources in bit order: hsi, csi, hsi48, hse, lsi, lse, pll1, pll2, pll3.
  localparam int OSC_NUM     = 9;
  localparam int SYNC_STAGES = 2;
  localparam int REG_AW      = 2;
  localparam int REG_DW      = 16;

  typedef logic [OSC_NUM-1:0] osc_vec_t;
  typedef logic [1:0]         css_vec_t;
  typedef logic [REG_DW-1:0]  rcc_word_t;
  typedef logic [REG_AW-1:0]  rcc_addr_t;

  // Bit positions inside css_vec_t.
  localparam int CSS_LSE_IDX = 0;
  localparam int CSS_HSE_IDX = 1;

  localparam rcc_addr_t ADDR_RDY = 2'd0;
  localparam rcc_addr_t ADDR_IER = 2'd1;
  localparam rcc_addr_t ADDR_IFR = 2'd2;
  localparam rcc_addr_t ADDR_ICR = 2'd3;

  // Field layout shared by IER, IFR and ICR.
  localparam int        OSC_FIELD_LSB = 0;
  localparam int        CSS_LSE_BIT   = 9;
  localparam int        CSS_HSE_BIT   = 10;
  localparam rcc_word_t FIELD_MASK    = 16'h07FF;

endpackage

`default_nettype wire
